//--- Bender.yml
package:
  name: bbox_mem

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/bbox_mem_pkg.sv
      - src/bbox_mem_if.sv
      - src/frame_write_seq.sv
      - src/history_frame_buffer.sv
      - src/history_read_seq.sv
      - src/bbox_mem_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_clock_gen.sv
      - verification/bbox_mem_tb.sv

//--- include/bbox_mem_macros.svh
// size definitions for the bounding-box history memory
// data, frame number, slot, line offset and history widths

`ifndef BBOX_MEM_MACROS_SVH
`define BBOX_MEM_MACROS_SVH

// one bounding-box word
`define BBOX_WIDTH 32

// serial number of a frame, 0 to 255
`define FRAME_NUM_WIDTH 8

// frame slots, power of two so the slot index wraps for free
`define SLOT_NUM 8
`define SLOT_WIDTH 3

// pair lines in one slot and the index into them
`define LINES_PER_SLOT 16
`define OFFSET_WIDTH 4

// line count runs 0 to 16
`define COUNT_WIDTH 5

// history distance runs 0 to 7
`define HIST_WIDTH 3

`endif

//--- sim.f
+incdir+include
src/bbox_mem_pkg.sv
src/bbox_mem_if.sv
src/frame_write_seq.sv
src/history_frame_buffer.sv
src/history_read_seq.sv
src/bbox_mem_top.sv
verification/tb_clock_gen.sv
verification/bbox_mem_tb.sv

//--- src/bbox_mem_if.sv
// internal bus between the sequencers and the frame buffer
// writer, reader and mem modports

`include "bbox_mem_macros.svh"

interface bbox_mem_if;
	import bbox_mem_pkg::*;

	// write port and frame open
	logic                      wr_en;
	logic [`SLOT_WIDTH-1:0]    wr_slot;
	logic [`OFFSET_WIDTH-1:0]  wr_offset;
	bbox_pair_t                wr_pair;
	logic                      open_en;
	logic [`SLOT_WIDTH-1:0]    open_slot;

	// read port
	logic [`SLOT_WIDTH-1:0]    rd_slot;
	logic [`OFFSET_WIDTH-1:0]  rd_offset;
	logic                      rd_en;
	bbox_pair_t                rd_pair;

	// buffer status
	logic [`COUNT_WIDTH-1:0]   slot_count;
	logic [`SLOT_WIDTH:0]      frames_stored;

	modport writer (
		output wr_en, wr_slot, wr_offset, wr_pair, open_en, open_slot
	);

	modport reader (
		output rd_slot, rd_offset, rd_en,
		input  rd_pair, slot_count, frames_stored
	);

	modport mem (
		input  wr_en, wr_slot, wr_offset, wr_pair, open_en, open_slot,
		input  rd_slot, rd_offset, rd_en,
		output rd_pair, slot_count, frames_stored
	);

endinterface

//--- src/bbox_mem_pkg.sv
// shared types of the bounding-box history memory
// write and read sequencer states, bbox pair struct

`include "bbox_mem_macros.svh"

package bbox_mem_pkg;

	// one stored line, two bounding-box words
	typedef struct packed {
		logic [`BBOX_WIDTH-1:0] box_0;
		logic [`BBOX_WIDTH-1:0] box_1;
	} bbox_pair_t;

	// write side handshake
	typedef enum logic {
		wr_idle,
		wr_ack_hold
	} wr_state_e;

	// read session walk
	typedef enum logic [2:0] {
		rd_idle,
		rd_seek,
		rd_wait_req,
		rd_fetch,
		rd_ack_hold,
		rd_done
	} rd_state_e;

endpackage

//--- src/bbox_mem_top.sv
// top level of the bounding-box history memory
// write sequencer, frame buffer and read sequencer on one internal bus

`include "bbox_mem_macros.svh"

module bbox_mem_top (
	input  logic                        clk,
	input  logic                        reset,
	// write channel from the processing element
	input  logic                        frame_start,
	input  logic [`FRAME_NUM_WIDTH-1:0] frame_num,
	input  logic                        wr_req,
	input  logic [`BBOX_WIDTH-1:0]      data_in_0,
	input  logic [`BBOX_WIDTH-1:0]      data_in_1,
	output logic                        wr_ack,
	// read channel from the similarity engine
	input  logic                        read_start,
	input  logic [`HIST_WIDTH-1:0]      num_of_history_frames,
	input  logic                        rd_req,
	output logic                        rd_ack,
	output logic [`BBOX_WIDTH-1:0]      data_out_0,
	output logic [`BBOX_WIDTH-1:0]      data_out_1,
	output logic [`HIST_WIDTH-1:0]      rd_hist,
	output logic                        rd_last,
	output logic                        rd_empty
);

	// frame number of the slot being written
	logic [`FRAME_NUM_WIDTH-1:0] current_frame;

	bbox_mem_if mem_bus ();

	// ----------------------------------------
	// producer
	// ----------------------------------------
	frame_write_seq u_write_seq (
		.clk           (clk),
		.reset         (reset),
		.frame_start   (frame_start),
		.frame_num     (frame_num),
		.wr_req        (wr_req),
		.data_in_0     (data_in_0),
		.data_in_1     (data_in_1),
		.wr_ack        (wr_ack),
		.current_frame (current_frame),
		.bus           (mem_bus.writer)
	);

	// buffer
	history_frame_buffer u_frame_buffer (
		.clk   (clk),
		.reset (reset),
		.bus   (mem_bus.mem)
	);

	// ----------------------------------------
	// consumer
	// ----------------------------------------
	history_read_seq u_read_seq (
		.clk                   (clk),
		.reset                 (reset),
		.read_start            (read_start),
		.num_of_history_frames (num_of_history_frames),
		.rd_req                (rd_req),
		.current_frame         (current_frame),
		.rd_ack                (rd_ack),
		.data_out_0            (data_out_0),
		.data_out_1            (data_out_1),
		.rd_hist               (rd_hist),
		.rd_last               (rd_last),
		.rd_empty              (rd_empty),
		.bus                   (mem_bus.reader)
	);

endmodule

//--- src/frame_write_seq.sv
// write sequencer of the history memory
// four-phase write handshake, current slot and line offset

`include "bbox_mem_macros.svh"

module frame_write_seq (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        frame_start,
	input  logic [`FRAME_NUM_WIDTH-1:0] frame_num,
	input  logic                        wr_req,
	input  logic [`BBOX_WIDTH-1:0]      data_in_0,
	input  logic [`BBOX_WIDTH-1:0]      data_in_1,
	output logic                        wr_ack,
	output logic [`FRAME_NUM_WIDTH-1:0] current_frame,
	bbox_mem_if.writer                  bus
);
	import bbox_mem_pkg::*;

	wr_state_e               state;
	logic [`SLOT_WIDTH-1:0]  cur_slot;
	logic [`COUNT_WIDTH-1:0] line_cnt;
	logic                    slot_full;
	logic                    take;

	// ----------------------------------------
	// handshake
	// ----------------------------------------

	// first cycle of a new request
	assign take = (state == wr_idle) && wr_req;

	// ack follows the hold state
	assign wr_ack = (state == wr_ack_hold);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= wr_idle;
		end else begin
			case (state)
				wr_idle: begin
					if (wr_req) begin
						state <= wr_ack_hold;
					end
				end
				// wait for the source to drop req
				wr_ack_hold: begin
					if (!wr_req) begin
						state <= wr_idle;
					end
				end
				default: begin
					state <= wr_idle;
				end
			endcase
		end
	end

	// ----------------------------------------
	// slot and line offset
	// ----------------------------------------

	// slot holds 16 lines, more get acked and dropped
	assign slot_full = (line_cnt == `COUNT_WIDTH'(`LINES_PER_SLOT));

	always_ff @(posedge clk) begin
		if (reset) begin
			cur_slot      <= '0;
			line_cnt      <= '0;
			current_frame <= '0;
		end else if (frame_start) begin
			// new frame takes slot frame mod 8
			cur_slot      <= frame_num[`SLOT_WIDTH-1:0];
			current_frame <= frame_num;
			line_cnt      <= '0;
		end else if (bus.wr_en) begin
			line_cnt <= line_cnt + 1'b1;
		end
	end

	// memory write on the same edge that raises ack
	assign bus.wr_en     = take && !slot_full;
	assign bus.wr_slot   = cur_slot;
	assign bus.wr_offset = line_cnt[`OFFSET_WIDTH-1:0];
	assign bus.wr_pair   = '{box_0: data_in_0, box_1: data_in_1};

	// clear the slot count when its frame opens
	assign bus.open_en   = frame_start;
	assign bus.open_slot = frame_num[`SLOT_WIDTH-1:0];

endmodule

//--- src/history_frame_buffer.sv
// history frame buffer
// slot array, per-slot line counts, stored-frame counter

`include "bbox_mem_macros.svh"

module history_frame_buffer (
	input  logic   clk,
	input  logic   reset,
	bbox_mem_if.mem bus
);
	import bbox_mem_pkg::*;

	// 8 slots of 16 pair lines
	bbox_pair_t              pair_mem [`SLOT_NUM][`LINES_PER_SLOT];
	logic [`COUNT_WIDTH-1:0] line_count [`SLOT_NUM];
	logic [`SLOT_WIDTH:0]    frames_cnt;

	// ----------------------------------------
	// storage
	// ----------------------------------------

	// write port
	always_ff @(posedge clk) begin
		if (bus.wr_en) begin
			pair_mem[bus.wr_slot][bus.wr_offset] <= bus.wr_pair;
		end
	end

	// registered read port, one cycle after rd_en
	always_ff @(posedge clk) begin
		if (bus.rd_en) begin
			bus.rd_pair <= pair_mem[bus.rd_slot][bus.rd_offset];
		end
	end

	// ----------------------------------------
	// line counts
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `SLOT_NUM; i++) begin
				line_count[i] <= '0;
			end
		end else begin
			// writer saturates its offset, so count stops at 16
			if (bus.wr_en) begin
				line_count[bus.wr_slot] <= line_count[bus.wr_slot] + 1'b1;
			end
			// reused slot starts empty
			if (bus.open_en) begin
				line_count[bus.open_slot] <= '0;
			end
		end
	end

	// count of the slot being looked at by the reader
	assign bus.slot_count = line_count[bus.rd_slot];

	// ----------------------------------------
	// stored frames
	// ----------------------------------------

	// saturates once every slot has held a frame
	always_ff @(posedge clk) begin
		if (reset) begin
			frames_cnt <= '0;
		end else if (bus.open_en && (frames_cnt != (`SLOT_WIDTH+1)'(`SLOT_NUM))) begin
			frames_cnt <= frames_cnt + 1'b1;
		end
	end

	assign bus.frames_stored = frames_cnt;

endmodule

//--- src/history_read_seq.sv
// read sequencer of the history memory
// session control, newest-first history walk, four-phase read handshake

`include "bbox_mem_macros.svh"

module history_read_seq (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         read_start,
	input  logic [`HIST_WIDTH-1:0]       num_of_history_frames,
	input  logic                         rd_req,
	input  logic [`FRAME_NUM_WIDTH-1:0]  current_frame,
	output logic                         rd_ack,
	output logic [`BBOX_WIDTH-1:0]       data_out_0,
	output logic [`BBOX_WIDTH-1:0]       data_out_1,
	output logic [`HIST_WIDTH-1:0]       rd_hist,
	output logic                         rd_last,
	output logic                         rd_empty,
	bbox_mem_if.reader                   bus
);
	import bbox_mem_pkg::*;

	rd_state_e                state;
	logic [`SLOT_WIDTH-1:0]   base_slot;
	logic [`HIST_WIDTH-1:0]   hist_max;
	logic [`HIST_WIDTH:0]     seek_idx;
	logic [`HIST_WIDTH:0]     hist_idx;
	logic [`HIST_WIDTH:0]     walk_idx;
	logic [`COUNT_WIDTH-1:0]  cur_count;
	logic [`COUNT_WIDTH-1:0]  next_off;
	logic [`OFFSET_WIDTH-1:0] line_off;
	logic                     have_cur;
	logic                     has_next;
	logic                     seek_end;
	logic                     start_ok;
	logic [`SLOT_WIDTH:0]     stored_dec;
	logic [`HIST_WIDTH-1:0]   stored_prev;
	logic [`HIST_WIDTH-1:0]   hist_lim;

	// ----------------------------------------
	// session limits
	// ----------------------------------------

	// frames older than the current one
	assign stored_dec  = bus.frames_stored - 1'b1;
	assign stored_prev = (bus.frames_stored == '0) ? '0 : stored_dec[`HIST_WIDTH-1:0];
	assign hist_lim    = (num_of_history_frames < stored_prev) ? num_of_history_frames
	                                                           : stored_prev;

	assign start_ok = read_start && ((state == rd_idle) || (state == rd_done));
	assign seek_end = (seek_idx > {1'b0, hist_max});
	assign next_off = {1'b0, line_off} + 1'b1;

	// seek looks ahead, other states address the frame being delivered
	assign walk_idx      = (state == rd_seek) ? seek_idx : hist_idx;
	assign bus.rd_slot   = base_slot - walk_idx[`SLOT_WIDTH-1:0];
	assign bus.rd_offset = line_off;
	assign bus.rd_en     = (state == rd_wait_req) && rd_req;

	assign rd_ack = (state == rd_ack_hold);

	// ----------------------------------------
	// session FSM
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= rd_idle;
			base_slot <= '0;
			hist_max  <= '0;
			seek_idx  <= '0;
			hist_idx  <= '0;
			cur_count <= '0;
			line_off  <= '0;
			have_cur  <= 1'b0;
			has_next  <= 1'b0;
			rd_last   <= 1'b0;
			rd_empty  <= 1'b0;
		end else begin
			case (state)
				rd_idle, rd_done: begin
					// latch C and H, start one frame back
					if (start_ok) begin
						base_slot <= current_frame[`SLOT_WIDTH-1:0];
						hist_max  <= hist_lim;
						seek_idx  <= (`HIST_WIDTH+1)'(1);
						line_off  <= '0;
						have_cur  <= 1'b0;
						has_next  <= 1'b0;
						rd_last   <= 1'b0;
						rd_empty  <= 1'b0;
						state     <= rd_seek;
					end
				end
				// one cycle per frame looked at
				rd_seek: begin
					if (seek_end) begin
						has_next <= 1'b0;
						if (have_cur) begin
							state <= rd_wait_req;
						end else begin
							// nothing at all left in this session
							rd_empty <= 1'b1;
							state    <= rd_done;
						end
					end else if (bus.slot_count == '0) begin
						seek_idx <= seek_idx + 1'b1;
					end else if (!have_cur) begin
						// frame to deliver, keep looking for a later one
						have_cur  <= 1'b1;
						hist_idx  <= seek_idx;
						cur_count <= bus.slot_count;
						seek_idx  <= seek_idx + 1'b1;
					end else begin
						has_next <= 1'b1;
						state    <= rd_wait_req;
					end
				end
				rd_wait_req: begin
					if (rd_req) begin
						state <= rd_fetch;
					end
				end
				// rd_pair valid here
				rd_fetch: begin
					rd_last <= !has_next && (next_off == cur_count);
					state   <= rd_ack_hold;
				end
				rd_ack_hold: begin
					if (!rd_req) begin
						if (rd_last) begin
							rd_empty <= 1'b1;
							state    <= rd_done;
						end else if (next_off < cur_count) begin
							line_off <= line_off + 1'b1;
							state    <= rd_wait_req;
						end else begin
							// seek_idx already sits on the next non-empty frame
							line_off <= '0;
							have_cur <= 1'b0;
							state    <= rd_seek;
						end
					end
				end
				default: begin
					state <= rd_idle;
				end
			endcase
		end
	end

	// ----------------------------------------
	// output data, held until the next fetch
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			data_out_0 <= '0;
			data_out_1 <= '0;
			rd_hist    <= '0;
		end else if (state == rd_fetch) begin
			data_out_0 <= bus.rd_pair.box_0;
			data_out_1 <= bus.rd_pair.box_1;
			rd_hist    <= hist_idx[`HIST_WIDTH-1:0];
		end
	end

endmodule

//--- verification/bbox_mem_tb.sv
// testbench of the bounding-box history memory
// directed tests, slot model with expected-line queues, value check, timeout loops

`include "bbox_mem_macros.svh"

module bbox_mem_tb;

	localparam int DRIVE_DLY = 2;
	localparam int TIMEOUT   = 100;

	logic clk;
	logic reset;
	logic frame_start;
	logic [`FRAME_NUM_WIDTH-1:0] frame_num;
	logic wr_req;
	logic [`BBOX_WIDTH-1:0] data_in_0;
	logic [`BBOX_WIDTH-1:0] data_in_1;
	logic wr_ack;
	logic read_start;
	logic [`HIST_WIDTH-1:0] num_of_history_frames;
	logic rd_req;
	logic rd_ack;
	logic [`BBOX_WIDTH-1:0] data_out_0;
	logic [`BBOX_WIDTH-1:0] data_out_1;
	logic [`HIST_WIDTH-1:0] rd_hist;
	logic rd_last;
	logic rd_empty;

	// model of the slots, pair is {box_0, box_1}
	logic [63:0] model_mem [8][16];
	int model_count [8];
	int model_stored;
	int model_slot;
	logic [7:0] model_frame;
	// lines the current read session should deliver
	int exp_hist [$];
	logic [63:0] exp_pair [$];

	tb_clock_gen u_clock_gen (.clk(clk), .reset(reset));

	bbox_mem_top u_dut (
		.clk(clk), .reset(reset),
		.frame_start(frame_start), .frame_num(frame_num), .wr_req(wr_req),
		.data_in_0(data_in_0), .data_in_1(data_in_1), .wr_ack(wr_ack),
		.read_start(read_start), .num_of_history_frames(num_of_history_frames),
		.rd_req(rd_req), .rd_ack(rd_ack), .data_out_0(data_out_0),
		.data_out_1(data_out_1), .rd_hist(rd_hist), .rd_last(rd_last),
		.rd_empty(rd_empty)
	);

	// ----------------------------------------
	// checks and timing
	// ----------------------------------------
	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp) begin
			$display("ERR time=%0t %s got=%0h expected=%0h", $time, name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timed out at %0t waiting for %s", $time, what);
		$display("TEST FAILED");
		$fatal(1, "timeout");
	endtask

	// drive and sample point, a little after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	// ----------------------------------------
	// write channel
	// ----------------------------------------
	task automatic open_frame(input logic [7:0] f);
		next_cycle();
		frame_start = 1'b1;
		frame_num   = f;
		next_cycle();
		frame_start = 1'b0;
		model_slot  = f % 8;
		model_frame = f;
		model_count[model_slot] = 0;
		if (model_stored < 8) model_stored++;
	endtask

	task automatic write_pair(input logic [31:0] d0, input logic [31:0] d1,
			input int hold);
		int n;
		next_cycle();
		data_in_0 = d0;
		data_in_1 = d1;
		wr_req    = 1'b1;
		n = 0;
		next_cycle();
		while (!wr_ack) begin
			n++;
			if (n > TIMEOUT) report_timeout("wr_ack to rise");
			next_cycle();
		end
		// full slot drops the line
		if (model_count[model_slot] < 16) begin
			model_mem[model_slot][model_count[model_slot]] = {d0, d1};
			model_count[model_slot]++;
		end
		repeat (hold) begin
			next_cycle();
			check_value("wr_ack", wr_ack, 1);
		end
		wr_req = 1'b0;
		n = 0;
		next_cycle();
		while (wr_ack) begin
			n++;
			if (n > TIMEOUT) report_timeout("wr_ack to fall");
			next_cycle();
		end
	endtask

	task automatic write_lines(input int lines, input int hold);
		repeat (lines) write_pair($urandom, $urandom, hold);
	endtask

	// ----------------------------------------
	// read channel
	// ----------------------------------------
	task automatic start_read(input int num);
		int h_lim;
		int slot;
		next_cycle();
		read_start = 1'b1;
		num_of_history_frames = num;
		next_cycle();
		read_start = 1'b0;
		// newest history frame first, current frame never read
		h_lim = (model_stored == 0) ? 0 : model_stored - 1;
		if (num < h_lim) h_lim = num;
		exp_hist.delete();
		exp_pair.delete();
		for (int h = 1; h <= h_lim; h++) begin
			slot = (model_frame - h) % 8;
			for (int l = 0; l < model_count[slot]; l++) begin
				exp_hist.push_back(h);
				exp_pair.push_back(model_mem[slot][l]);
			end
		end
	endtask

	task automatic read_line(input int hold);
		int n;
		int hist;
		logic [63:0] pair;
		logic last;
		pair = exp_pair.pop_front();
		hist = exp_hist.pop_front();
		last = (exp_pair.size() == 0);
		next_cycle();
		rd_req = 1'b1;
		n = 0;
		next_cycle();
		while (!rd_ack) begin
			n++;
			if (n > TIMEOUT) report_timeout("rd_ack to rise");
			next_cycle();
		end
		check_value("rd_hist", rd_hist, hist);
		check_value("rd_last", rd_last, last);
		check_value("rd_empty", rd_empty, 0);
		// data must stay put while req is held
		for (int c = 0; c <= hold; c++) begin
			if (c > 0) next_cycle();
			check_value("rd_ack", rd_ack, 1);
			check_value("data_out_0", data_out_0, pair[63:32]);
			check_value("data_out_1", data_out_1, pair[31:0]);
		end
		rd_req = 1'b0;
		n = 0;
		next_cycle();
		while (rd_ack) begin
			n++;
			if (n > TIMEOUT) report_timeout("rd_ack to fall");
			next_cycle();
		end
	endtask

	// whole session, ends on rd_empty
	task automatic read_session(input int num, input int hold);
		int n;
		start_read(num);
		while (exp_pair.size() > 0) read_line(hold);
		n = 0;
		while (!rd_empty) begin
			n++;
			if (n > TIMEOUT) report_timeout("rd_empty at end of session");
			check_value("rd_ack", rd_ack, 0);
			next_cycle();
		end
	endtask

	// ----------------------------------------
	// directed tests
	// ----------------------------------------
	task automatic reset_and_empty_read();
		check_value("wr_ack", wr_ack, 0);
		check_value("rd_ack", rd_ack, 0);
		check_value("rd_last", rd_last, 0);
		check_value("rd_empty", rd_empty, 0);
		check_value("data_out_0", data_out_0, 0);
		check_value("data_out_1", data_out_1, 0);
		check_value("rd_hist", rd_hist, 0);
		read_session(3, 0);
		// no frame open yet, so these land in slot 0
		// slot 0 sits beyond every clamped session until the wrap
		write_lines(2, 0);
	endtask

	// frame 2 left empty so the walk skips it
	task automatic skip_empty_frame();
		open_frame(8'd1);
		write_lines(1 + $urandom % 5, 0);
		open_frame(8'd2);
		open_frame(8'd3);
		write_lines($urandom % 6, 0);
		read_session(2, 0);
	endtask

	task automatic clamp_history();
		read_session(7, 0);
	endtask

	task automatic drop_extra_lines();
		open_frame(8'd5);
		write_lines(18, 0);
		open_frame(8'd6);
		read_session(1, 0);
	endtask

	// ten frames over eight slots, frame 14 empty
	task automatic wrap_slots();
		for (int k = 0; k < 10; k++) begin
			open_frame(8'(10 + k));
			if (k < 2) write_lines(6, 0);
			else if (k != 4) write_lines(1 + $urandom % 3, 0);
		end
		read_session(7, 0);
	endtask

	task automatic hold_both_channels();
		open_frame(8'd20);
		fork
			write_lines(3, 6);
			read_session(3, 5);
		join
		// lines written under a held req, one line per handshake
		open_frame(8'd21);
		read_session(1, 0);
	endtask

	initial begin
		int n;
		void'($urandom(32'hf784));
		frame_start = 1'b0;
		frame_num = '0;
		wr_req = 1'b0;
		data_in_0 = '0;
		data_in_1 = '0;
		read_start = 1'b0;
		num_of_history_frames = '0;
		rd_req = 1'b0;
		for (int s = 0; s < 8; s++) model_count[s] = 0;
		model_stored = 0;
		model_slot = 0;
		model_frame = '0;
		n = 0;
		next_cycle();
		while (reset) begin
			n++;
			if (n > TIMEOUT) report_timeout("reset release");
			next_cycle();
		end
		reset_and_empty_read();
		skip_empty_frame();
		clamp_history();
		drop_extra_lines();
		wrap_slots();
		hold_both_channels();
		$display("TEST PASSED");
		$finish;
	end

endmodule

//--- verification/tb_clock_gen.sv
// testbench clock and reset generator
// 40 unit clock period, reset high for the first five cycles

module tb_clock_gen (
	output logic clk,
	output logic reset
);

	localparam int HALF_PERIOD  = 20;
	localparam int RESET_CYCLES = 5;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// release just after an edge, like the other inputs
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		reset = 1'b0;
	end

endmodule
